//--- dbg_unit.f
hdl/dbg_unit_pkg.sv
hdl/dbg_bp_match.sv
hdl/dbg_port.sv
hdl/dbg_regs.sv
hdl/dbg_unit.sv
test/dbg_unit_sva.sv
test/tb_dbg_unit.sv

//--- Makefile
SRCS := $(shell cat dbg_unit.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dbg_unit: $(SRCS) dbg_unit.f
	verilator --binary --timing --assert -Wno-fatal -f dbg_unit.f \
		--top-module tb_dbg_unit -o Vtb_dbg_unit

run: obj_dir/Vtb_dbg_unit
	./obj_dir/Vtb_dbg_unit | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_dbg_unit.sv
////////////////////
// Debug unit testbench with random stimulus, shadow model and checks
////////////////////

`timescale 1ns/1ps

module tb_dbg_unit;

  localparam int N1 = 40, N2 = 30, N3 = 40, N4 = 20, N5 = 30, N6 = 60;
  localparam int LIMIT = 200 * (N1 + N2 + N3 + N4 + N5 + N6);

  logic clk, rstn;
  logic dbg_stall, dbg_strb, dbg_we, dbg_ack, dbg_bp;
  logic [31:0] dbg_addr, dbg_dati, dbg_dato;
  logic du_stall, du_stall_dly, du_flush, du_we_rf, du_we_csr, du_we_pc;
  logic [11:0] du_addr;
  logic [31:0] du_dato, du_ie, du_dati_rf, st_csr_rval, if_pc, id_pc, ex_pc, bu_nxt_pc;
  logic bu_flush, st_flush, if_bubble, mem_bubble, dmem_ack, ex_stall;
  logic [31:0] if_instr, mem_instr, mem_exception, mem_memadr, du_exceptions;

  int seed = 32'h661f_9e2c;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // Shadow model of the internal bank
  logic [1:0]  m_ctrl;
  logic [31:0] m_hit, m_ie, m_cause;
  logic        m_bpen [2];
  logic [2:0]  m_bpcc [2];
  logic [31:0] m_bpdata [2];

  dbg_unit dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("ERROR: run exceeded %0d cycles without finishing", LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] model_int(input logic [11:0] off);
    int n;
    model_int = '0;
    n = (int'(off) - 16) >> 1;
    case (off)
      12'h000: model_int = {30'h0, m_ctrl};
      12'h001: model_int = m_hit;
      12'h002: model_int = m_ie;
      12'h003: model_int = m_cause;
      12'h010, 12'h012: model_int = {25'h0, m_bpcc[n], 2'b00, m_bpen[n], 1'b1};
      12'h011, 12'h013: model_int = m_bpdata[n];
      default: model_int = '0;
    endcase
  endfunction

  // One debug access, returns read data, latency and the strobes seen
  task automatic bus(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                     input logic stall_rand, output logic [31:0] rdata, output int lat,
                     output logic [3:0] strobes);
    logic [31:0] r;
    logic [3:0]  stb_now;
    lat = 0;
    strobes = '0;
    @(posedge clk);
    #1;
    dbg_strb = 1'b1;
    dbg_we   = we;
    dbg_addr = addr;
    dbg_dati = wdata;
    forever begin
      @(posedge clk);
      #1;
      lat++;
      stb_now = {dut_i.du_we_int, du_we_pc, du_we_csr, du_we_rf};
      // Each strobe pulses for a single cycle
      checks++;
      assert ((strobes & stb_now) == 4'b0000)
      else begin
        $display("ERROR: write strobe pulsed more than once for access to %h", addr);
        errors++;
      end
      strobes |= stb_now;
      if (we && lat == 1) begin
        check("du_addr", {20'h0, du_addr}, {20'h0, addr[11:0]});
        check("du_dato", du_dato, wdata);
      end
      if (dbg_ack) break;
      if (lat > 100) begin
        $display("ERROR: no acknowledge for access to %h", addr);
        errors++;
        break;
      end
      r = $random(seed);
      ex_stall = stall_rand & r[0];
    end
    rdata = dbg_dato;
    ex_stall = 1'b0;
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    int lat;
    logic [3:0] stb;
    bus(1'b1, addr, data, 1'b0, rd, lat, stb);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    int lat;
    logic [3:0] stb;
    bus(1'b0, addr, 32'h0, 1'b0, rd, lat, stb);
    check(name, rd, exp);
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %-14s done, %0d errors", name, errors - err_before);
  endtask

  initial begin
    logic [31:0] r, d, rd, exp;
    logic [11:0] off;
    logic [3:0]  stb;
    logic [2:0]  cc;
    logic [4:0]  opc;
    logic        prev, cur, match;
    int          lat, e0, n;

    // Quiet core with bubbles everywhere, no flush and no exceptions
    rstn = 1'b0;
    {dbg_stall, dbg_strb, dbg_we, ex_stall, bu_flush, st_flush, dmem_ack} = '0;
    {dbg_addr, dbg_dati, du_dati_rf, st_csr_rval, id_pc, ex_pc, bu_nxt_pc} = '0;
    {if_instr, mem_instr, mem_exception, mem_memadr, du_exceptions} = '0;
    if_bubble = 1'b1;
    mem_bubble = 1'b1;
    if_pc = 32'hffff_fff0;
    m_ctrl = '0;
    m_hit = '0;
    m_ie = '0;
    m_cause = '0;
    for (int i = 0; i < 2; i++) begin
      m_bpen[i] = 1'b0;
      m_bpcc[i] = '0;
      m_bpdata[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;

    ////////////////////
    // Internal registers
    e0 = errors;
    for (int i = 0; i < N1; i++) begin
      r = $random(seed);
      d = $random(seed);
      n = r[4];
      case (r[2:0])
        3'd0: begin
          write_reg(32'h0, d);
          m_ctrl = d[1:0];
        end
        3'd1: begin
          write_reg(32'h2, d);
          m_ie = d;
        end
        3'd2: begin
          write_reg(32'h10 + 2 * n, d);
          m_bpen[n] = d[1];
          m_bpcc[n] = d[6:4];
        end
        3'd3: begin
          // Kept clear of the idle fetch PC
          d = d & 32'h7fff_fff0;
          write_reg(32'h11 + 2 * n, d);
          m_bpdata[n] = d;
        end
        default: begin
          case (r[7:5])
            3'd0, 3'd1, 3'd2: off = {9'h0, r[7:5]};
            3'd3: off = 12'h003;
            3'd4: off = 12'h010 + {10'h0, r[9:8]};
            3'd5: off = 12'h004;
            3'd6: off = 12'h020;
            default: off = 12'h100 + {4'h0, r[15:8]};
          endcase
          read_check("dbg_dato", {20'h0, off}, model_int(off));
        end
      endcase
      check("du_ie", du_ie, m_ie);
    end
    report("internal_regs", e0);

    ////////////////////
    // Acknowledge
    e0 = errors;
    dbg_stall = 1'b1;
    for (int i = 0; i < N2; i++) begin
      r = $random(seed);
      bus(1'b0, 32'h0, 32'h0, r[0], rd, lat, stb);
      check("dbg_dato", rd, model_int(12'h000));
      if (!r[0]) check("ack_latency", lat, 3);
    end
    dbg_stall = 1'b0;
    @(posedge clk);
    #1;
    dbg_strb = 1'b1;
    dbg_addr = 32'h0000_1000;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      #1;
      checks++;
      assert (!dbg_ack)
      else begin
        $display("ERROR: core bank acknowledged while the core was running");
        errors++;
      end
    end
    dbg_strb = 1'b0;
    report("acknowledge", e0);

    ////////////////////
    // Core banks
    e0 = errors;
    dbg_stall = 1'b1;
    for (int i = 0; i < N3; i++) begin
      r = $random(seed);
      d = $random(seed);
      du_dati_rf  = $random(seed);
      st_csr_rval = $random(seed);
      id_pc       = $random(seed);
      ex_pc       = $random(seed);
      bu_nxt_pc   = $random(seed);
      bu_flush    = r[8];
      case (r[2:0])
        3'd0: begin
          bus(1'b1, {20'h1, 7'h0, r[20:16]}, d, 1'b0, rd, lat, stb);
          check("du_we_rf", stb, 4'b0001);
        end
        3'd1: begin
          bus(1'b1, 32'h0000_1200, d, 1'b0, rd, lat, stb);
          check("du_we_pc", stb, 4'b0100);
        end
        3'd2: begin
          bus(1'b1, {20'h2, r[27:16]}, d, 1'b0, rd, lat, stb);
          check("du_we_csr", stb, 4'b0010);
        end
        3'd3: read_check("gpr_read", {20'h1, 7'h0, r[20:16]}, du_dati_rf);
        3'd4: read_check("npc_read", 32'h0000_1200, r[8] ? bu_nxt_pc : id_pc);
        3'd5: read_check("ppc_read", 32'h0000_1201, ex_pc);
        default: read_check("csr_read", {20'h2, r[27:16]}, st_csr_rval);
      endcase
    end
    bu_flush = 1'b0;
    report("core_banks", e0);

    ////////////////////
    // Cause
    e0 = errors;
    for (int i = 0; i < N4; i++) begin
      r = $random(seed);
      d = $random(seed);
      case (r[1:0])
        2'd0: d = d & 32'h0000_ffff;
        2'd1: d = d & 32'hffff_0000;
        default: ;
      endcase
      if (d == 0) d = 32'h0001_0000 << r[5:2];
      @(posedge clk);
      #1 du_exceptions = d;
      repeat (2) @(posedge clk);
      #1 du_exceptions = '0;
      // Lowest trap first, then lowest interrupt with the top bit
      exp = 32'hffff_ffff;
      for (int b = 15; b >= 0; b--) begin
        if (d[b]) exp = b;
      end
      if (exp == 32'hffff_ffff) begin
        for (int b = 15; b >= 0; b--) begin
          if (d[16 + b]) exp = 32'h8000_0000 | b;
        end
      end
      m_cause = exp;
      read_check("cause", 32'h3, m_cause);
    end
    report("cause", e0);

    ////////////////////
    // Breakpoints
    e0 = errors;
    dbg_stall = 1'b0;
    for (int i = 0; i < N5; i++) begin
      r = $random(seed);
      d = $random(seed) & 32'h7fff_fff0;
      n = r[0];
      cc = {1'b0, r[2:1]};
      match = r[3];
      write_reg(32'h0, {30'h0, r[5:4]});
      m_ctrl = r[5:4];
      write_reg(32'h10 + 2 * (1 - n), 32'h0);
      write_reg(32'h10 + 2 * n, {25'h0, cc, 4'b0010});
      write_reg(32'h11 + 2 * n, d);
      write_reg(32'h1, 32'h0);
      m_hit = '0;
      opc = r[7] ? 5'b11000 : (r[6] ? 5'b01000 : 5'b00000);
      @(posedge clk);
      #1;
      if (cc == 3'd0) begin
        if_bubble = 1'b0;
        if_pc = match ? d : d ^ 32'h4;
        if_instr = {25'h0, opc, 2'b11};
        m_hit[0] = m_ctrl[0];
        m_hit[1] = m_ctrl[1] && opc == 5'b11000;
        m_hit[4 + n] = match;
      end else begin
        mem_bubble = 1'b0;
        dmem_ack = 1'b1;
        mem_memadr = match ? d : d ^ 32'h8;
        mem_instr = {25'h0, opc, 2'b11};
        m_hit[4 + n] = match && ((opc == 5'b00000 && cc != 3'd2) ||
                                 (opc == 5'b01000 && cc != 3'd1));
      end
      @(posedge clk);
      #1;
      if_bubble = 1'b1;
      mem_bubble = 1'b1;
      dmem_ack = 1'b0;
      if_pc = 32'hffff_fff0;
      @(posedge clk);
      #1 check("dbg_bp", dbg_bp, |m_hit);
      read_check("hit", 32'h1, m_hit);
      write_reg(32'h0, 32'h0);
      m_ctrl = '0;
      write_reg(32'h1, 32'h0);
      m_hit = '0;
      read_check("hit_cleared", 32'h1, 32'h0);
    end
    report("breakpoints", e0);

    ////////////////////
    // Stall and flush
    e0 = errors;
    @(posedge clk);
    #1 prev = dbg_stall;
    for (int i = 0; i < N6; i++) begin
      @(posedge clk);
      #1;
      r = $random(seed);
      cur = r[0];
      dbg_stall = cur;
      du_exceptions = r[1] ? 32'h0 : $random(seed);
      #5;
      check("du_stall", du_stall, cur);
      check("du_stall_dly", du_stall_dly, prev);
      check("du_flush", du_flush, prev & ~cur & (|du_exceptions));
      prev = cur;
    end
    dbg_stall = 1'b0;
    du_exceptions = '0;
    report("stall_flush", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- test/dbg_unit_sva.sv
////////////////////
// Debug port protocol and strobe assertions
////////////////////

`timescale 1ns/1ps

module dbg_port_sva (
  input logic clk,
  input logic rstn,
  input logic dbg_ack,
  input logic access,
  input logic du_we_rf,
  input logic du_we_csr,
  input logic du_we_pc,
  input logic du_we_int
);

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |=> !dbg_ack)
    else $error("dbg_ack held for two cycles");

  // One write target at a time
  strobe_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({du_we_rf, du_we_csr, du_we_pc, du_we_int}))
    else $error("more than one write strobe active");

  // Access held through the whole ack fill
  ack_needs_access: assert property (@(posedge clk) disable iff (!rstn)
    $rose(dbg_ack) |-> $past(access) && $past(access, 2) && $past(access, 3))
    else $error("dbg_ack rose without an accepted access");

endmodule

bind dbg_port dbg_port_sva sva_i (.*);

//--- hdl/dbg_unit.sv
////////////////////
// Debug unit top: stall, flush, breakpoint output
////////////////////

`timescale 1ns/1ps

module dbg_unit (
  input  logic                                  clk,
  input  logic                                  rstn,
  // Debugger port
  input  logic                                  dbg_stall,
  input  logic                                  dbg_strb,
  input  logic                                  dbg_we,
  input  logic [dbg_unit_pkg::PLEN-1:0]         dbg_addr,
  input  logic [dbg_unit_pkg::XLEN-1:0]         dbg_dati,
  output logic [dbg_unit_pkg::XLEN-1:0]         dbg_dato,
  output logic                                  dbg_ack,
  output logic                                  dbg_bp,
  // Core control
  output logic                                  du_stall,
  output logic                                  du_stall_dly,
  output logic                                  du_flush,
  output logic                                  du_we_rf,
  output logic                                  du_we_csr,
  output logic                                  du_we_pc,
  output logic [dbg_unit_pkg::DU_ADDR_SIZE-1:0] du_addr,
  output logic [dbg_unit_pkg::XLEN-1:0]         du_dato,
  output logic [dbg_unit_pkg::XLEN-1:0]         du_ie,
  // Core state
  input  logic [dbg_unit_pkg::XLEN-1:0]         du_dati_rf,
  input  logic [dbg_unit_pkg::XLEN-1:0]         st_csr_rval,
  input  logic [dbg_unit_pkg::XLEN-1:0]         if_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]         id_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]         ex_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]         bu_nxt_pc,
  input  logic                                  bu_flush,
  input  logic                                  st_flush,
  input  logic [dbg_unit_pkg::XLEN-1:0]         if_instr,
  input  logic [dbg_unit_pkg::XLEN-1:0]         mem_instr,
  input  logic                                  if_bubble,
  input  logic                                  mem_bubble,
  input  logic [dbg_unit_pkg::EXC_SIZE-1:0]     mem_exception,
  input  logic [dbg_unit_pkg::XLEN-1:0]         mem_memadr,
  input  logic                                  dmem_ack,
  input  logic                                  ex_stall,
  input  logic [dbg_unit_pkg::EXC_SIZE-1:0]     du_exceptions
);

  logic                                 du_we_int;
  logic [dbg_unit_pkg::XLEN-1:0]        int_rdata;
  logic                                 instr_break_ena;
  logic                                 branch_break_ena;
  logic [dbg_unit_pkg::BREAKPOINTS-1:0] bp_enabled;
  dbg_unit_pkg::bp_cc_e [dbg_unit_pkg::BREAKPOINTS-1:0] bp_cc;
  logic [dbg_unit_pkg::BREAKPOINTS-1:0][dbg_unit_pkg::XLEN-1:0] bp_data;
  logic [dbg_unit_pkg::BREAKPOINTS-1:0] bp_hit;
  logic                                 instr_hit;
  logic                                 branch_hit;
  logic                                 any_hit;

  ////////////////////
  // Stall and flush
  ////////////////////

  assign du_stall = dbg_stall;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_stall_dly <= 1'b0;
    end else begin
      du_stall_dly <= dbg_stall;
    end
  end

  // Stall released with exceptions pending
  assign du_flush = du_stall_dly & ~dbg_stall & (|du_exceptions);

  // Break to the debugger only on a quiet pipeline
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_bp <= 1'b0;
    end else begin
      dbg_bp <= ~ex_stall & ~du_stall & ~du_flush & ~bu_flush & ~st_flush &
                ((|du_exceptions) | any_hit);
    end
  end

  ////////////////////
  // Submodules
  ////////////////////

  dbg_port port_i (
    .clk, .rstn, .dbg_stall, .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati,
    .dbg_ack, .dbg_dato, .ex_stall, .du_dati_rf, .st_csr_rval, .id_pc,
    .ex_pc, .bu_nxt_pc, .bu_flush, .int_rdata, .du_addr, .du_dato,
    .du_we_rf, .du_we_csr, .du_we_pc, .du_we_int
  );

  dbg_regs regs_i (
    .clk, .rstn, .du_we_int, .du_addr, .du_dato, .du_exceptions,
    .bp_hit, .instr_hit, .branch_hit, .int_rdata, .du_ie,
    .instr_break_ena, .branch_break_ena, .bp_enabled, .bp_cc, .bp_data,
    .any_hit
  );

  dbg_bp_match match_i (
    .instr_break_ena, .branch_break_ena, .bp_enabled, .bp_cc, .bp_data,
    .if_pc, .if_instr, .if_bubble, .mem_instr, .mem_bubble, .mem_exception,
    .mem_memadr, .dmem_ack, .bu_flush, .st_flush, .bp_hit, .instr_hit,
    .branch_hit
  );

endmodule

//--- hdl/dbg_regs.sv
////////////////////
// Internal debug registers, cause encoder, read mux
////////////////////

`timescale 1ns/1ps

module dbg_regs (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  du_we_int,
  input  logic [dbg_unit_pkg::DU_ADDR_SIZE-1:0] du_addr,
  input  logic [dbg_unit_pkg::XLEN-1:0]         du_dato,
  input  logic [dbg_unit_pkg::EXC_SIZE-1:0]     du_exceptions,
  input  logic [dbg_unit_pkg::BREAKPOINTS-1:0]  bp_hit,
  input  logic                                  instr_hit,
  input  logic                                  branch_hit,
  output logic [dbg_unit_pkg::XLEN-1:0]         int_rdata,
  output logic [dbg_unit_pkg::XLEN-1:0]         du_ie,
  output logic                                  instr_break_ena,
  output logic                                  branch_break_ena,
  output logic [dbg_unit_pkg::BREAKPOINTS-1:0]  bp_enabled,
  output dbg_unit_pkg::bp_cc_e [dbg_unit_pkg::BREAKPOINTS-1:0] bp_cc,
  output logic [dbg_unit_pkg::BREAKPOINTS-1:0][dbg_unit_pkg::XLEN-1:0] bp_data,
  output logic                                  any_hit
);

  logic                                     hit_instr;
  logic                                     hit_branch;
  logic [dbg_unit_pkg::BREAKPOINTS-1:0]     hit_bp;
  logic [dbg_unit_pkg::XLEN-1:0]            cause;
  logic [dbg_unit_pkg::XLEN-1:0]            trap_cause;
  logic [dbg_unit_pkg::XLEN-1:0]            irq_cause;
  logic                                     trap_any;
  logic                                     irq_any;
  logic                                     bp_sel;
  logic [2:0]                               bp_idx;

  // Breakpoint window: 0x01x, index in bits 3..1, data on bit 0
  assign bp_sel = (du_addr[dbg_unit_pkg::DU_ADDR_SIZE-1:4] ==
                   dbg_unit_pkg::DBG_BPCTRL0[dbg_unit_pkg::DU_ADDR_SIZE-1:4]);
  assign bp_idx = du_addr[3:1];

  ////////////////////
  // CTRL, IE
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
      du_ie            <= '0;
    end else if (du_we_int) begin
      if (du_addr == dbg_unit_pkg::DBG_CTRL) begin
        instr_break_ena  <= du_dato[0];
        branch_break_ena <= du_dato[1];
      end
      if (du_addr == dbg_unit_pkg::DBG_IE) begin
        du_ie <= du_dato;
      end
    end
  end

  ////////////////////
  // Sticky hits
  ////////////////////

  // Debugger write overrides the pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hit_instr  <= 1'b0;
      hit_branch <= 1'b0;
      hit_bp     <= '0;
    end else if (du_we_int && du_addr == dbg_unit_pkg::DBG_HIT) begin
      hit_instr  <= du_dato[0];
      hit_branch <= du_dato[1];
      hit_bp     <= du_dato[4 +: dbg_unit_pkg::BREAKPOINTS];
    end else begin
      hit_instr  <= hit_instr | instr_hit;
      hit_branch <= hit_branch | branch_hit;
      hit_bp     <= hit_bp | bp_hit;
    end
  end

  assign any_hit = hit_instr | hit_branch | (|hit_bp);

  ////////////////////
  // Cause
  ////////////////////

  assign trap_any = |du_exceptions[dbg_unit_pkg::EXC_SIZE/2-1:0];
  assign irq_any  = |du_exceptions[dbg_unit_pkg::EXC_SIZE-1:dbg_unit_pkg::EXC_SIZE/2];

  // Lowest set bit wins, so scan downwards
  always_comb begin
    trap_cause = '0;
    irq_cause  = '0;
    for (int i = dbg_unit_pkg::EXC_SIZE/2 - 1; i >= 0; i--) begin
      if (du_exceptions[i]) begin
        trap_cause = i;
      end
      if (du_exceptions[i + dbg_unit_pkg::EXC_SIZE/2]) begin
        irq_cause = i;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause <= '0;
    end else if (du_we_int) begin
      if (du_addr == dbg_unit_pkg::DBG_CAUSE) begin
        cause <= du_dato;
      end
    end else if (trap_any) begin
      cause <= trap_cause;
    end else if (irq_any) begin
      // Interrupts carry the top bit
      cause <= {1'b1, irq_cause[dbg_unit_pkg::XLEN-2:0]};
    end
  end

  ////////////////////
  // Breakpoint registers
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_enabled <= '0;
      bp_data    <= '0;
      for (int n = 0; n < dbg_unit_pkg::BREAKPOINTS; n++) begin
        bp_cc[n] <= dbg_unit_pkg::CC_FETCH;
      end
    end else if (du_we_int && bp_sel) begin
      for (int n = 0; n < dbg_unit_pkg::BREAKPOINTS; n++) begin
        if (bp_idx == n && !du_addr[0]) begin
          bp_enabled[n] <= du_dato[1];
          bp_cc[n]      <= dbg_unit_pkg::bp_cc_e'(du_dato[6:4]);
        end
        if (bp_idx == n && du_addr[0]) begin
          bp_data[n] <= du_dato;
        end
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    int_rdata = '0;
    case (du_addr)
      dbg_unit_pkg::DBG_CTRL: begin
        int_rdata[1:0] = {branch_break_ena, instr_break_ena};
      end
      dbg_unit_pkg::DBG_HIT: begin
        int_rdata[1:0] = {hit_branch, hit_instr};
        int_rdata[4 +: dbg_unit_pkg::BREAKPOINTS] = hit_bp;
      end
      dbg_unit_pkg::DBG_IE:    int_rdata = du_ie;
      dbg_unit_pkg::DBG_CAUSE: int_rdata = cause;
      default: begin
        for (int n = 0; n < dbg_unit_pkg::BREAKPOINTS; n++) begin
          if (bp_sel && bp_idx == n) begin
            if (du_addr[0]) begin
              int_rdata = bp_data[n];
            end else begin
              // Bit 0 reads as implemented
              int_rdata[6:0] = {bp_cc[n], 2'b00, bp_enabled[n], 1'b1};
            end
          end
        end
      end
    endcase
  end

endmodule

//--- hdl/dbg_port.sv
////////////////////
// Debug port: bank decode, acknowledge, write strobes
// and registered read data
////////////////////

`timescale 1ns/1ps

module dbg_port (
  input  logic                                  clk,
  input  logic                                  rstn,
  // Debugger side
  input  logic                                  dbg_stall,
  input  logic                                  dbg_strb,
  input  logic                                  dbg_we,
  input  logic [dbg_unit_pkg::PLEN-1:0]         dbg_addr,
  input  logic [dbg_unit_pkg::XLEN-1:0]         dbg_dati,
  output logic                                  dbg_ack,
  output logic [dbg_unit_pkg::XLEN-1:0]         dbg_dato,
  // Core side
  input  logic                                  ex_stall,
  input  logic [dbg_unit_pkg::XLEN-1:0]         du_dati_rf,
  input  logic [dbg_unit_pkg::XLEN-1:0]         st_csr_rval,
  input  logic [dbg_unit_pkg::XLEN-1:0]         id_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]         ex_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]         bu_nxt_pc,
  input  logic                                  bu_flush,
  input  logic [dbg_unit_pkg::XLEN-1:0]         int_rdata,
  output logic [dbg_unit_pkg::DU_ADDR_SIZE-1:0] du_addr,
  output logic [dbg_unit_pkg::XLEN-1:0]         du_dato,
  output logic                                  du_we_rf,
  output logic                                  du_we_csr,
  output logic                                  du_we_pc,
  output logic                                  du_we_int
);

  logic [dbg_unit_pkg::PLEN-dbg_unit_pkg::DU_ADDR_SIZE-1:0] bank;
  logic [dbg_unit_pkg::DU_ADDR_SIZE-1:0]                    offset;
  logic                                                     sel_internal;
  logic                                                     sel_gprs;
  logic                                                     sel_csrs;
  logic                                                     is_gpr;
  logic                                                     strb_dly;
  logic                                                     access;
  logic                                                     first_we;
  logic [2:0]                                               ack_sr;

  ////////////////////
  // Decode
  ////////////////////

  assign bank   = dbg_addr[dbg_unit_pkg::PLEN-1:dbg_unit_pkg::DU_ADDR_SIZE];
  assign offset = dbg_addr[dbg_unit_pkg::DU_ADDR_SIZE-1:0];

  assign sel_internal = (bank == dbg_unit_pkg::DBG_INTERNAL);
  assign sel_gprs     = (bank == dbg_unit_pkg::DBG_GPRS);
  assign sel_csrs     = (bank == dbg_unit_pkg::DBG_CSRS);

  // GPR window 0x000..0x01F
  assign is_gpr = (offset[dbg_unit_pkg::DU_ADDR_SIZE-1:5] ==
                   dbg_unit_pkg::DBG_GPR[dbg_unit_pkg::DU_ADDR_SIZE-1:5]);

  // Core banks need the core stalled
  assign access   = dbg_strb & (dbg_stall | sel_internal);
  // Write only in the first strobe cycle
  assign first_we = access & ~strb_dly & dbg_we;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strb_dly <= 1'b0;
    end else begin
      strb_dly <= dbg_strb;
    end
  end

  ////////////////////
  // Acknowledge
  ////////////////////

  // Fills from the top, frozen while the core stalls
  // Emptied once the ack has gone out
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_sr <= 3'b000;
    end else if (!ex_stall) begin
      ack_sr <= {3{access & ~dbg_ack}} & {1'b1, ack_sr[2:1]};
    end
  end

  assign dbg_ack = ack_sr[0];

  ////////////////////
  // Write strobes
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_we_rf  <= 1'b0;
      du_we_csr <= 1'b0;
      du_we_pc  <= 1'b0;
      du_we_int <= 1'b0;
    end else begin
      du_we_rf  <= first_we & sel_gprs & is_gpr;
      du_we_pc  <= first_we & sel_gprs & (offset == dbg_unit_pkg::DBG_NPC);
      du_we_csr <= first_we & sel_csrs;
      du_we_int <= first_we & sel_internal;
    end
  end

  // Offset and data travel with the strobes
  always_ff @(posedge clk) begin
    du_addr <= offset;
    du_dato <= dbg_dati;
  end

  ////////////////////
  // Read data
  ////////////////////

  always_ff @(posedge clk) begin
    if (sel_internal) begin
      dbg_dato <= int_rdata;
    end else if (sel_gprs && is_gpr) begin
      dbg_dato <= du_dati_rf;
    end else if (sel_gprs && offset == dbg_unit_pkg::DBG_NPC) begin
      // Branch target wins during a flush
      dbg_dato <= bu_flush ? bu_nxt_pc : id_pc;
    end else if (sel_gprs && offset == dbg_unit_pkg::DBG_PPC) begin
      dbg_dato <= ex_pc;
    end else if (sel_csrs) begin
      dbg_dato <= st_csr_rval;
    end else begin
      dbg_dato <= '0;
    end
  end

endmodule

//--- hdl/dbg_bp_match.sv
////////////////////
// Breakpoint compare for fetch and memory accesses
////////////////////

`timescale 1ns/1ps

module dbg_bp_match (
  input  logic                                 instr_break_ena,
  input  logic                                 branch_break_ena,
  input  logic [dbg_unit_pkg::BREAKPOINTS-1:0] bp_enabled,
  input  dbg_unit_pkg::bp_cc_e [dbg_unit_pkg::BREAKPOINTS-1:0] bp_cc,
  input  logic [dbg_unit_pkg::BREAKPOINTS-1:0][dbg_unit_pkg::XLEN-1:0] bp_data,
  // Fetch stage
  input  logic [dbg_unit_pkg::XLEN-1:0]        if_pc,
  input  logic [dbg_unit_pkg::XLEN-1:0]        if_instr,
  input  logic                                 if_bubble,
  // Memory stage
  input  logic [dbg_unit_pkg::XLEN-1:0]        mem_instr,
  input  logic                                 mem_bubble,
  input  logic [dbg_unit_pkg::EXC_SIZE-1:0]    mem_exception,
  input  logic [dbg_unit_pkg::XLEN-1:0]        mem_memadr,
  input  logic                                 dmem_ack,
  input  logic                                 bu_flush,
  input  logic                                 st_flush,
  output logic [dbg_unit_pkg::BREAKPOINTS-1:0] bp_hit,
  output logic                                 instr_hit,
  output logic                                 branch_hit
);

  logic mem_valid;
  logic mem_read;
  logic mem_write;

  // Single step and branch break on any real fetch
  assign instr_hit  = instr_break_ena & ~if_bubble;
  assign branch_hit = branch_break_ena & ~if_bubble &
                      (if_instr[6:2] == dbg_unit_pkg::OPC_BRANCH);

  // Only clean memory-stage instructions count
  assign mem_valid = ~mem_bubble & ~(|mem_exception);
  assign mem_read  = mem_valid & (mem_instr[6:2] == dbg_unit_pkg::OPC_LOAD);
  assign mem_write = mem_valid & (mem_instr[6:2] == dbg_unit_pkg::OPC_STORE);

  always_comb begin
    bp_hit = '0;
    for (int n = 0; n < dbg_unit_pkg::BREAKPOINTS; n++) begin
      if (bp_enabled[n]) begin
        case (bp_cc[n])
          dbg_unit_pkg::CC_FETCH:
            bp_hit[n] = (if_pc == bp_data[n]) & ~bu_flush & ~st_flush;
          dbg_unit_pkg::CC_LD_ADR:
            bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_read;
          dbg_unit_pkg::CC_ST_ADR:
            bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_write;
          dbg_unit_pkg::CC_LDST_ADR:
            bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & (mem_read | mem_write);
          // Reserved codes
          default: bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

endmodule

//--- hdl/dbg_unit_pkg.sv
////////////////////
// Debug unit widths, address map, breakpoint conditions
// and the RISC-V opcodes the breakpoint logic decodes
////////////////////

package dbg_unit_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and debug address
  localparam int XLEN         = 32;
  localparam int PLEN         = 32;
  // Offset inside one bank
  localparam int DU_ADDR_SIZE = 12;
  localparam int BREAKPOINTS  = 2;
  // Low half traps, high half interrupts
  localparam int EXC_SIZE     = 32;

  ////////////////////
  // Address map
  ////////////////////

  // Bank numbers in the upper address bits
  localparam logic [PLEN-DU_ADDR_SIZE-1:0] DBG_INTERNAL = 'h0;
  localparam logic [PLEN-DU_ADDR_SIZE-1:0] DBG_GPRS     = 'h1;
  localparam logic [PLEN-DU_ADDR_SIZE-1:0] DBG_CSRS     = 'h2;

  // Internal bank
  localparam logic [DU_ADDR_SIZE-1:0] DBG_CTRL    = 12'h000;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_HIT     = 12'h001;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_IE      = 12'h002;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_CAUSE   = 12'h003;
  // Breakpoint n at base plus 2n
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPCTRL0 = 12'h010;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPDATA0 = 12'h011;

  // GPR bank, register index in the low 5 bits
  localparam logic [DU_ADDR_SIZE-1:0] DBG_GPR = 12'h000;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_NPC = 12'h200;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_PPC = 12'h201;

  ////////////////////
  // Encodings
  ////////////////////

  // Breakpoint condition, other codes never hit
  typedef enum logic [2:0] {
    CC_FETCH    = 3'h0,
    CC_LD_ADR   = 3'h1,
    CC_ST_ADR   = 3'h2,
    CC_LDST_ADR = 3'h3
  } bp_cc_e;

  // Major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_STORE  = 5'b01000,
    OPC_BRANCH = 5'b11000
  } opcode_e;

endpackage
